//--- filelist.f
+incdir+include
source/io_space_pkg.sv
source/io_decoder.sv
source/us_timer.sv
source/spi_master.sv
source/io_space_top.sv
sim/tb_io_space.sv

//--- Makefile
TOP = tb_io_space

.PHONY: sim clean

# Build with Verilator, run, and look for the pass line in the output
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- sim/tb_io_space.sv
`timescale 1ns/1ps
`include "io_space_consts.svh"

module tb_io_space import io_space_pkg::*; ();

    localparam int NUM_LED      = 16;
    localparam int NUM_UNMAPPED = 16;
    localparam int NUM_TMR      = 6;
    localparam int NUM_CS       = 16;
    localparam int NUM_XFER     = 8;
    localparam int MAX_GAP      = 200;
    // Each transfer takes two control writes, a data write, up to 21 status reads and a data read
    localparam int NUM_ACCESSES = 3 + 2 * NUM_LED + NUM_UNMAPPED + 2 * NUM_TMR
                                  + 2 * NUM_CS + NUM_XFER * 25;
    localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 40 + NUM_TMR * MAX_GAP + 500;

    logic       clk_48;
    logic       rst_n;
    io_req_t    req;
    io_rsp_t    rsp;
    logic [2:0] led;
    logic       spi_cs;
    logic       spi_clk;
    logic       spi_mosi;
    logic       spi_miso;

    int         cycle;
    int         errors;
    int         checks;
    logic       exp_ready;
    logic [7:0] slave_tx;
    logic [7:0] slave_rx;
    int         slave_bit;

    io_space_top uut (
        .clk_48   (clk_48),
        .rst_n    (rst_n),
        .req      (req),
        .rsp      (rsp),
        .led      (led),
        .spi_cs   (spi_cs),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    initial clk_48 = 1'b0;
    always #4 clk_48 = ~clk_48;

    always @(posedge clk_48) begin
        cycle <= cycle + 1;
    end

    // --------------------
    // Checking
    // --------------------

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // Ready must follow each region C strobe by exactly one cycle
    always @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            exp_ready <= 1'b0;
        end else begin
            exp_ready <= req.addr_strobe && (req.read_strobe || req.write_strobe)
                         && (req.address[31:28] == `IO_REGION);
        end
    end

    always @(negedge clk_48) begin
        if (rst_n) begin
            check("ready one cycle after strobe", 32'(exp_ready), 32'(rsp.ready));
        end
    end

    // --------------------
    // SPI slave model
    // --------------------

    always @(posedge spi_clk) begin
        slave_rx = {slave_rx[6:0], spi_mosi};
    end

    always @(negedge spi_clk) begin
        #1;
        if (slave_bit >= 0) begin
            spi_miso = slave_tx[slave_bit];
            slave_bit--;
        end
    end

    // --------------------
    // Bus driver
    // --------------------

    task automatic bus_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int strobe_cycle);
        int waits;
        waits = 0;
        req.addr_strobe  = 1'b1;
        req.read_strobe  = !is_write;
        req.write_strobe = is_write;
        req.address      = addr;
        req.byte_enable  = 4'hF;
        req.write_data   = wdata;
        @(posedge clk_48);
        #1;
        strobe_cycle     = cycle;
        req.addr_strobe  = 1'b0;
        req.read_strobe  = 1'b0;
        req.write_strobe = 1'b0;
        while (!rsp.ready && waits < 4) begin
            @(posedge clk_48);
            #1;
            waits++;
        end
        if (!rsp.ready) begin
            errors++;
            $display("No ready returned for the access to 0x%08h", addr);
        end
        rdata = rsp.read_data;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             output int strobe_cycle);
        logic [31:0] unused_rdata;
        bus_access(1'b1, addr, wdata, unused_rdata, strobe_cycle);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output int strobe_cycle);
        bus_access(1'b0, addr, 32'h0, rdata, strobe_cycle);
    endtask

    function automatic logic is_mapped(input logic [31:0] addr);
        logic [31:0] word;
        word = {addr[31:2], 2'b00};
        return (word == `REG_LED) || (word == `REG_TMR)
               || (word == `REG_SPI_CTRL) || (word == `REG_SPI_DATA);
    endfunction

    // --------------------
    // Watchdog
    // --------------------

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_48);
        $display("Watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // --------------------
    // Tests
    // --------------------

    initial begin
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [31:0] addr;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] delta;
        logic [7:0]  tx_byte;
        int          at;
        int          at2;
        int          gap;
        int          n;
        int          polls;

        void'($urandom(32'h8288_a1bb));
        rst_n     = 1'b0;
        req       = '0;
        spi_miso  = 1'b1;
        slave_bit = -1;
        slave_tx  = 8'h0;
        slave_rx  = 8'h0;
        repeat (5) @(posedge clk_48);
        #1;
        rst_n = 1'b1;

        check("led after reset", 32'(`LED_RESET), 32'(led));
        check("spi_cs after reset", 1, 32'(spi_cs));
        check("spi_clk after reset", 1, 32'(spi_clk));
        check("spi_mosi after reset", 1, 32'(spi_mosi));
        bus_read(`REG_SPI_CTRL, rdata, at);
        check("spi ctrl after reset", 32'h1, rdata);
        bus_read(`REG_TMR, rdata, at);
        check("timer after reset at most one", 1, 32'(rdata <= 32'd1));
        bus_read(`REG_LED, rdata, at);
        check("led read after reset", 32'(`LED_RESET), rdata);

        repeat (NUM_LED) begin
            wdata = $urandom;
            bus_write(`REG_LED, wdata, at);
            check("led output", 32'(wdata[2:0]), 32'(led));
            bus_read(`REG_LED, rdata, at);
            check("led read back", 32'(wdata[2:0]), rdata);
        end

        repeat (NUM_UNMAPPED) begin
            addr = {`IO_REGION, 28'($urandom)};
            while (is_mapped(addr)) begin
                addr = {`IO_REGION, 28'($urandom)};
            end
            bus_read(addr, rdata, at);
            check("unmapped read", 32'h0, rdata);
        end

        // One tick per 48 clocks, so the phase adds at most one
        repeat (NUM_TMR) begin
            gap = 1 + int'($urandom % MAX_GAP);
            bus_read(`REG_TMR, t1, at);
            repeat (gap - 1) @(posedge clk_48);
            #1;
            bus_read(`REG_TMR, t2, at2);
            n     = at2 - at;
            delta = t2 - t1;
            check($sformatf("timer delta %0d over %0d cycles", delta, n), 1,
                  32'((delta == 32'(n / 48)) || (delta == 32'(n / 48 + 1))));
        end

        repeat (NUM_CS) begin
            wdata = $urandom;
            bus_write(`REG_SPI_CTRL, wdata, at);
            check("spi_cs output", 32'(wdata[0]), 32'(spi_cs));
            bus_read(`REG_SPI_CTRL, rdata, at);
            check("spi ctrl read back", {31'h0, wdata[0]}, rdata);
        end

        repeat (NUM_XFER) begin
            bus_write(`REG_SPI_CTRL, 32'h0, at);
            tx_byte   = 8'($urandom);
            slave_tx  = 8'($urandom);
            slave_rx  = 8'h0;
            slave_bit = 7;
            spi_miso  = slave_tx[7];
            bus_write(`REG_SPI_DATA, {24'($urandom), tx_byte}, at);
            bus_read(`REG_SPI_CTRL, rdata, at2);
            check("busy right after data write", 1, 32'(rdata[1]));
            polls = 0;
            while (rdata[1] && polls < 20) begin
                bus_read(`REG_SPI_CTRL, rdata, at2);
                polls++;
            end
            if (rdata[1]) begin
                errors++;
                $display("SPI busy never cleared after the data write");
            end else begin
                check("busy clear cycles after write", 16, 32'(at2 - at));
            end
            check("slave received byte", 32'(tx_byte), 32'(slave_rx));
            bus_read(`REG_SPI_DATA, rdata, at2);
            check("spi data read", 32'(slave_tx), rdata);
            bus_write(`REG_SPI_CTRL, 32'h1, at);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- source/io_space_top.sv
`timescale 1ns/1ps

module io_space_top import io_space_pkg::*; (
    input  logic       clk_48,
    input  logic       rst_n,
    input  io_req_t    req,
    output io_rsp_t    rsp,
    output logic [2:0] led,
    output logic       spi_cs,
    output logic       spi_clk,
    output logic       spi_mosi,
    input  logic       spi_miso
);

    logic [31:0] tmr_count;
    spi_wr_t     spi_wr;
    spi_stat_t   spi_stat;

    // --------------------
    // Bus decode and LEDs
    // --------------------

    io_decoder u_io_decoder (
        .clk_48    (clk_48),
        .rst_n     (rst_n),
        .req       (req),
        .rsp       (rsp),
        .tmr_count (tmr_count),
        .spi_wr    (spi_wr),
        .spi_stat  (spi_stat),
        .led       (led)
    );

    // --------------------
    // Microsecond timer
    // --------------------

    us_timer u_us_timer (
        .clk_48 (clk_48),
        .rst_n  (rst_n),
        .count  (tmr_count)
    );

    // --------------------
    // SPI master
    // --------------------

    spi_master u_spi_master (
        .clk_48   (clk_48),
        .rst_n    (rst_n),
        .wr       (spi_wr),
        .stat     (spi_stat),
        .spi_cs   (spi_cs),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

endmodule

//--- source/spi_master.sv
`timescale 1ns/1ps
`include "io_space_consts.svh"

module spi_master import io_space_pkg::*; (
    input  logic      clk_48,
    input  logic      rst_n,
    input  spi_wr_t   wr,
    output spi_stat_t stat,
    output logic      spi_cs,
    output logic      spi_clk,
    output logic      spi_mosi,
    input  logic      spi_miso
);

    logic [3:0] bit_cnt;
    logic [7:0] shift_q;
    logic       busy;

    // --------------------
    // Chip select
    // --------------------

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            spi_cs <= 1'b1;
        end else begin
            if (wr.cs_we) begin
                spi_cs <= wr.cs_value;
            end
        end
    end

    // --------------------
    // Bit engine
    // --------------------

    // Each bit has a low phase that drives MOSI and a high phase that samples MISO
    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            spi_clk  <= 1'b1;
            spi_mosi <= 1'b1;
            bit_cnt  <= 4'd0;
        end else begin
            // Low phase lasts one clock even across a restart
            if (!spi_clk) begin
                spi_clk <= 1'b1;
            end

            if (wr.data_we) begin
                bit_cnt <= 4'(`SPI_BITS);
            end else if (spi_clk && (bit_cnt != 4'd0)) begin
                spi_clk  <= 1'b0;
                spi_mosi <= shift_q[7];
                bit_cnt  <= bit_cnt - 4'd1;
            end
        end
    end

    // Transmit byte shifts out at the top and received bits enter at the bottom
    always_ff @(posedge clk_48) begin
        if (wr.data_we) begin
            shift_q <= wr.data;
        end else if (!spi_clk) begin
            shift_q[0] <= spi_miso;
        end else if (bit_cnt != 4'd0) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    // --------------------
    // Status
    // --------------------

    assign busy = (bit_cnt != 4'd0) || !spi_clk;

    assign stat = '{
        cs:      spi_cs,
        busy:    busy,
        rx_data: shift_q
    };

    // --------------------
    // Checks
    // --------------------

    a_clk_low_one_cycle: assert property (
        @(posedge clk_48) disable iff (!rst_n)
        !spi_clk |=> spi_clk
    );

endmodule

//--- source/us_timer.sv
`timescale 1ns/1ps
`include "io_space_consts.svh"

module us_timer (
    input  logic        clk_48,
    input  logic        rst_n,
    output logic [31:0] count
);

    logic [5:0]  prescale;
    logic        tick;
    logic [31:0] count_q;

    // Last clock of each microsecond
    assign tick = (prescale == 6'(`TMR_PRESCALE - 1));

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            prescale <= 6'd0;
            count_q  <= 32'd0;
        end else begin
            if (tick) begin
                prescale <= 6'd0;
                // Wraps freely at 2^32
                count_q  <= count_q + 32'd1;
            end else begin
                prescale <= prescale + 6'd1;
            end
        end
    end

    assign count = count_q;

    // --------------------
    // Checks
    // --------------------

    a_prescale_range: assert property (
        @(posedge clk_48) disable iff (!rst_n)
        prescale < 6'(`TMR_PRESCALE)
    );

endmodule

//--- source/io_decoder.sv
`timescale 1ns/1ps
`include "io_space_consts.svh"

module io_decoder import io_space_pkg::*; (
    input  logic        clk_48,
    input  logic        rst_n,
    input  io_req_t     req,
    output io_rsp_t     rsp,
    input  logic [31:0] tmr_count,
    output spi_wr_t     spi_wr,
    input  spi_stat_t   spi_stat,
    output logic [2:0]  led
);

    logic [31:0] word_addr;
    logic        access;
    logic        region_hit;
    logic        wr_byte0;
    logic        ready_q;
    logic [2:0]  led_q;
    logic [31:0] read_data;

    // --------------------
    // Decode
    // --------------------

    assign word_addr  = {req.address[31:2], 2'b00};
    assign access     = req.addr_strobe && (req.read_strobe || req.write_strobe);
    assign region_hit = access && (req.address[31:28] == `IO_REGION);

    // Every register bit sits in byte lane 0
    assign wr_byte0 = region_hit && req.write_strobe && req.byte_enable[0];

    // --------------------
    // Ready pulse
    // --------------------

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= region_hit;
        end
    end

    // --------------------
    // LED register
    // --------------------

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            led_q <= `LED_RESET;
        end else begin
            if (wr_byte0 && (word_addr == `REG_LED)) begin
                led_q <= req.write_data[2:0];
            end
        end
    end

    // All three bits are software controlled
    assign led = led_q;

    // --------------------
    // SPI write pulses
    // --------------------

    assign spi_wr = '{
        cs_we:    wr_byte0 && (word_addr == `REG_SPI_CTRL),
        data_we:  wr_byte0 && (word_addr == `REG_SPI_DATA),
        cs_value: req.write_data[0],
        data:     req.write_data[7:0]
    };

    // --------------------
    // Read data
    // --------------------

    // Follows the held address and is sampled by the CPU on ready
    always_comb begin
        read_data = 32'h0;
        case (word_addr)
            `REG_LED: begin
                read_data = {29'h0, led_q};
            end
            `REG_TMR: begin
                read_data = tmr_count;
            end
            `REG_SPI_CTRL: begin
                read_data = {30'h0, spi_stat.busy, spi_stat.cs};
            end
            `REG_SPI_DATA: begin
                read_data = {24'h0, spi_stat.rx_data};
            end
            default: begin
                read_data = 32'h0;
            end
        endcase
    end

    always_comb begin
        rsp.ready     = ready_q;
        rsp.read_data = read_data;
    end

    // --------------------
    // Checks
    // --------------------

    // Ready answers a region C strobe from the previous cycle only
    a_ready_follows_strobe: assert property (
        @(posedge clk_48) disable iff (!rst_n)
        rsp.ready |-> $past(req.addr_strobe
                            && (req.read_strobe || req.write_strobe)
                            && (req.address[31:28] == `IO_REGION))
    );

endmodule

//--- source/io_space_pkg.sv
package io_space_pkg;

    // --------------------
    // CPU I/O bus
    // --------------------

    // Request held by the CPU until ready
    typedef struct packed {
        logic        addr_strobe;
        logic        read_strobe;
        logic        write_strobe;
        logic [31:0] address;
        logic [3:0]  byte_enable;
        logic [31:0] write_data;
    } io_req_t;

    // Response with a single-cycle ready pulse
    typedef struct packed {
        logic        ready;
        logic [31:0] read_data;
    } io_rsp_t;

    // --------------------
    // SPI master link
    // --------------------

    // Decoded write pulses from the decoder
    typedef struct packed {
        logic       cs_we;
        logic       data_we;
        logic       cs_value;
        logic [7:0] data;
    } spi_wr_t;

    // Status levels back to the decoder
    typedef struct packed {
        logic       cs;
        logic       busy;
        logic [7:0] rx_data;
    } spi_stat_t;

endpackage

//--- include/io_space_consts.svh
`ifndef IO_SPACE_CONSTS_SVH
`define IO_SPACE_CONSTS_SVH

// --------------------
// Address map
// --------------------

// Top nibble of the clk_48 I/O region
`define IO_REGION       4'hC

// LED bits in the low three bits of the word
`define REG_LED         32'hC000_0000

// Free-running microsecond count
`define REG_TMR         32'hC000_0004

// Chip select in bit 0 and busy in bit 1
`define REG_SPI_CTRL    32'hC000_0020

// Write starts a transfer and read returns the received byte
`define REG_SPI_DATA    32'hC000_0024

// --------------------
// Timing and sizes
// --------------------

// 48 MHz down to 1 MHz
`define TMR_PRESCALE    48

// One byte per transfer
`define SPI_BITS        8

// --------------------
// Reset values
// --------------------

`define LED_RESET       3'b100

`endif
